//--- hdl/fixed_pkg.sv
/*
 * fixed-point number format (widths, fraction bits)
 * signed value type and complex coordinate struct
 */
package fixed_pkg;

    localparam int FUNCW  = 25;              // width of every value
    localparam int FP_INT = 4;               // integer bits incl. sign
    localparam int FBITS  = FUNCW - FP_INT;  // fractional bits

    typedef logic signed [FUNCW-1:0] fixed_t;

    typedef struct packed {
        fixed_t re;
        fixed_t im;
    } cplx_t;

endpackage

//--- hdl/mandel_pkg.sv
/*
 * tile geometry, iteration limit and engine count
 * point and result structs, engine and dispatcher state enums
 */
package mandel_pkg;
    import fixed_pkg::*;

    localparam int ITER_MAX = 255;              // iteration limit
    localparam int ITERW    = 8;
    localparam int TILE_W   = 8;                // points per row
    localparam int TILE_H   = 6;                // rows per tile
    localparam int TILE_PTS = TILE_W * TILE_H;
    localparam int COORDW   = 3;
    localparam int NUM_ENG  = 4;                // iteration engines
    localparam int ENGW     = 2;

    typedef struct packed {
        logic [COORDW-1:0] px;
        logic [COORDW-1:0] py;
        cplx_t             c;
    } point_t;

    typedef struct packed {
        logic [COORDW-1:0] px;
        logic [COORDW-1:0] py;
        logic [ITERW-1:0]  iter;
    } result_t;

    typedef enum logic [2:0] {IDLE, TEST, MUL_XY, ADD_X, MUL_XX, MUL_YY} eng_state_e;
    typedef enum logic {DISP_IDLE, DISP_RUN} disp_state_e;

endpackage

//--- hdl/fixed_mul.sv
/*
 * signed fixed-point multiplier, two register stages
 * start and done strobes, done two cycles after start
 */
`timescale 1ns/1ps

module fixed_mul
    import fixed_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  fixed_t a,
    input  fixed_t b,
    output logic   done,
    output fixed_t val
);

    fixed_t                    a_r;
    fixed_t                    b_r;
    logic signed [2*FUNCW-1:0] prod;  // full-width product
    logic [1:0]                vld;   // valid chain, one bit per stage

    assign prod = a_r * b_r;
    assign done = vld[1];

    always_ff @(posedge clk) begin
        if (start) begin
            a_r <= a;
            b_r <= b;
        end
        if (vld[0]) begin
            val <= fixed_t'(prod >>> FBITS);  // drop fraction, wraps
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 2'b00;
        end else begin
            vld <= {vld[0], start};
        end
    end

    // the engine waits for done before issuing the next product
    assert property (@(posedge clk) disable iff (rst) start |-> (vld == 2'b00))
        else $error("multiplier started with a product in flight");

endmodule

//--- hdl/mandel_engine.sv
/*
 * escape-time iteration engine for one point
 * one shared multiplier used three times per iteration
 */
`timescale 1ns/1ps

module mandel_engine
    import fixed_pkg::*;
    import mandel_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  point_t  point,
    output logic    done,
    output result_t result,
    output logic    calculating
);

    eng_state_e       state;
    point_t           pt_r;    // captured point and pixel position
    fixed_t           x;
    fixed_t           y;
    fixed_t           x2;      // x squared
    fixed_t           y2;      // y squared
    fixed_t           mag;     // x2 + y2 for the escape test
    fixed_t           xy;      // x * y from the multiplier
    logic [ITERW-1:0] iter;

    logic   mul_start;
    logic   mul_done;
    fixed_t mul_a;
    fixed_t mul_b;
    fixed_t mul_val;
    fixed_t x_next;            // x2 - y2 + c.re
    logic   keep_going;

    fixed_mul mul0 (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .done  (mul_done),
        .val   (mul_val)
    );

    assign x_next     = x2 - y2 + pt_r.c.re;
    assign keep_going = (mag[FUNCW-1 -: FP_INT] <= FP_INT'(4)) && (int'(iter) < ITER_MAX);
    assign result     = '{px: pt_r.px, py: pt_r.py, iter: iter};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            calculating <= 1'b0;
            done        <= 1'b0;
            mul_start   <= 1'b0;
        end else begin
            done      <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state       <= TEST;
                    calculating <= 1'b1;
                    pt_r        <= point;
                    x           <= '0;  // z starts at zero
                    y           <= '0;
                    x2          <= '0;
                    y2          <= '0;
                    mag         <= '0;
                    iter        <= '0;
                end
                TEST: begin
                    if (keep_going) begin
                        state     <= MUL_XY;
                        mul_a     <= x;
                        mul_b     <= y;
                        mul_start <= 1'b1;
                    end else begin
                        state       <= IDLE;
                        calculating <= 1'b0;
                        done        <= 1'b1;
                    end
                end
                MUL_XY: if (mul_done) begin
                    state <= ADD_X;
                    xy    <= mul_val;
                end
                ADD_X: begin
                    state     <= MUL_XX;
                    x         <= x_next;
                    y         <= (xy <<< 1) + pt_r.c.im;  // 2xy + c.im
                    mul_a     <= x_next;
                    mul_b     <= x_next;
                    mul_start <= 1'b1;
                end
                MUL_XX: if (mul_done) begin
                    state     <= MUL_YY;
                    x2        <= mul_val;
                    mul_a     <= y;                       // new y already in place
                    mul_b     <= y;
                    mul_start <= 1'b1;
                end
                MUL_YY: if (mul_done) begin
                    state <= TEST;
                    y2    <= mul_val;
                    mag   <= x2 + mul_val;
                    iter  <= iter + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) done |-> ($past(state) == TEST))
        else $error("engine done raised outside the escape test");

endmodule

//--- hdl/point_dispatch.sv
/*
 * raster walk over the tile, running complex coordinates
 * starts the lowest-numbered free engine, one per cycle
 */
`timescale 1ns/1ps

module point_dispatch
    import fixed_pkg::*;
    import mandel_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  cplx_t              origin,
    input  fixed_t             step,
    input  logic [NUM_ENG-1:0] eng_free,
    output logic [NUM_ENG-1:0] eng_start,
    output point_t             eng_point
);

    disp_state_e        state;
    logic [COORDW-1:0]  px;        // next point to hand out
    logic [COORDW-1:0]  py;
    cplx_t              cur;       // its complex value
    fixed_t             row_re;    // real part at column 0
    fixed_t             step_r;
    logic [COORDW-1:0]  b_px;      // base values, tile origin when idle
    logic [COORDW-1:0]  b_py;
    cplx_t              b_c;
    fixed_t             b_row_re;
    fixed_t             b_step;
    logic               active;
    logic               issue;
    logic               last;
    logic [NUM_ENG-1:0] pick;      // lowest free engine, one-hot

    assign active = (state == DISP_RUN) || start;
    assign issue  = active && (|eng_free);
    assign last   = (b_px == COORDW'(TILE_W - 1)) && (b_py == COORDW'(TILE_H - 1));

    always_comb begin
        if (state == DISP_IDLE) begin
            b_px     = '0;
            b_py     = '0;
            b_c      = origin;
            b_row_re = origin.re;
            b_step   = step;
        end else begin
            b_px     = px;
            b_py     = py;
            b_c      = cur;
            b_row_re = row_re;
            b_step   = step_r;
        end
    end

    always_comb begin
        pick = '0;
        for (int i = NUM_ENG - 1; i >= 0; i--) begin
            if (eng_free[i]) begin
                pick = NUM_ENG'(1) << i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DISP_IDLE;
            eng_start <= '0;
        end else begin
            eng_start <= issue ? pick : '0;
            if (active) begin
                state  <= DISP_RUN;
                step_r <= b_step;
                row_re <= b_row_re;
                px     <= b_px;
                py     <= b_py;
                cur    <= b_c;
                if (issue) begin
                    eng_point <= '{px: b_px, py: b_py, c: b_c};
                    if (last) begin
                        state <= DISP_IDLE;             // whole tile handed out
                    end else if (b_px == COORDW'(TILE_W - 1)) begin
                        px     <= '0;
                        py     <= b_py + 1'b1;
                        cur.re <= b_row_re;
                        cur.im <= b_c.im + b_step;
                    end else begin
                        px     <= b_px + 1'b1;
                        cur.re <= b_c.re + b_step;
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        |eng_start |-> $onehot(eng_start) && ((eng_start & ~$past(eng_free)) == '0))
        else $error("engine started while not free");

endmodule

//--- hdl/result_collect.sv
/*
 * per-engine result slots drained round-robin to one strobe
 * engine free flags, busy level and tile_done pulse
 */
`timescale 1ns/1ps

module result_collect
    import mandel_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [NUM_ENG-1:0] eng_done,
    input  result_t            eng_result [NUM_ENG],
    input  logic [NUM_ENG-1:0] eng_calc,
    input  logic [NUM_ENG-1:0] eng_start,
    output logic [NUM_ENG-1:0] eng_free,
    output logic               out_valid,
    output result_t            out_result,
    output logic               busy,
    output logic               tile_done
);

    result_t                     slot [NUM_ENG];
    logic [NUM_ENG-1:0]          full;
    logic [ENGW-1:0]             rr;    // slot looked at this cycle
    logic [$clog2(TILE_PTS)-1:0] sent;  // results emitted in this tile

    assign eng_free   = ~eng_calc & ~eng_done & ~eng_start & ~full;
    assign out_valid  = full[rr];
    assign out_result = slot[rr];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENG; i++) begin
            if (eng_done[i]) begin
                slot[i] <= eng_result[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full      <= '0;
            rr        <= '0;
            sent      <= '0;
            busy      <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            rr        <= rr + 1'b1;  // visits every slot each NUM_ENG cycles
            for (int i = 0; i < NUM_ENG; i++) begin
                if (eng_done[i]) begin
                    full[i] <= 1'b1;
                end
            end
            if (out_valid) begin
                full[rr] <= 1'b0;
                if (int'(sent) == TILE_PTS - 1) begin
                    sent      <= '0;
                    busy      <= 1'b0;
                    tile_done <= 1'b1;
                end else begin
                    sent <= sent + 1'b1;
                end
            end
            if (start && !busy) begin
                busy <= 1'b1;
            end
        end
    end

    for (genvar g = 0; g < NUM_ENG; g++) begin : g_chk
        assert property (@(posedge clk) disable iff (rst) eng_done[g] |-> !full[g])
            else $error("engine %0d finished into a full slot", g);
    end

endmodule

//--- hdl/mandel_tile.sv
/*
 * tile renderer top: dispatcher, engine array, collector
 */
`timescale 1ns/1ps

module mandel_tile
    import fixed_pkg::*;
    import mandel_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  cplx_t   origin,
    input  fixed_t  step,
    output logic    out_valid,
    output result_t out_result,
    output logic    busy,
    output logic    tile_done
);

    logic [NUM_ENG-1:0] eng_start;
    logic [NUM_ENG-1:0] eng_free;
    logic [NUM_ENG-1:0] eng_done;
    logic [NUM_ENG-1:0] eng_calc;
    point_t             eng_point;  // shared, taken by the started engine
    result_t            eng_result [NUM_ENG];
    logic               tile_go;    // start seen only while idle

    assign tile_go = start & ~busy;

    point_dispatch disp0 (
        .clk       (clk),
        .rst       (rst),
        .start     (tile_go),
        .origin    (origin),
        .step      (step),
        .eng_free  (eng_free),
        .eng_start (eng_start),
        .eng_point (eng_point)
    );

    for (genvar g = 0; g < NUM_ENG; g++) begin : g_eng
        mandel_engine eng (
            .clk         (clk),
            .rst         (rst),
            .start       (eng_start[g]),
            .point       (eng_point),
            .done        (eng_done[g]),
            .result      (eng_result[g]),
            .calculating (eng_calc[g])
        );
    end

    result_collect coll0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .eng_done   (eng_done),
        .eng_result (eng_result),
        .eng_calc   (eng_calc),
        .eng_start  (eng_start),
        .eng_free   (eng_free),
        .out_valid  (out_valid),
        .out_result (out_result),
        .busy       (busy),
        .tile_done  (tile_done)
    );

endmodule

//--- tb/tb_mandel_tile.sv
/*
 * testbench for the tile renderer: clock, reset, fixed and random tiles
 * bit-exact escape-time model, per-pixel scoreboard and report
 */
`timescale 1ns/1ps

module tb_mandel_tile
    import fixed_pkg::*;
    import mandel_pkg::*;
();

    localparam int TILE_TIMEOUT = 60000;  // cycles, worst tile is about 35000

    logic    clk;
    logic    rst;
    logic    start;
    cplx_t   origin;
    fixed_t  step;
    logic    out_valid;
    result_t out_result;
    logic    busy;
    logic    tile_done;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     failed_tests;
    int     out_count;   // out_valid strobes in this tile
    int     done_count;  // tile_done pulses in this tile
    int     ooo_count;   // results that came before an earlier raster index
    int     last_idx;
    int     exp_iter [TILE_W][TILE_H];
    int     got_iter [TILE_W][TILE_H];
    int     seen     [TILE_W][TILE_H];

    always #4 clk = ~clk;

    mandel_tile dut0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .origin     (origin),
        .step       (step),
        .out_valid  (out_valid),
        .out_result (out_result),
        .busy       (busy),
        .tile_done  (tile_done)
    );

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %0t %s: expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    function automatic longint wrap(input longint v);
        fixed_t t;
        t = fixed_t'(v);  // keep FUNCW bits, sign extend
        return longint'(t);
    endfunction

    function automatic longint fmul(input longint a, input longint b);
        longint p;
        p = a * b;
        return wrap(p >>> FBITS);
    endfunction

    function automatic int model_iter(input longint cre, input longint cim);
        longint            x;
        longint            y;
        longint            x2;
        longint            y2;
        longint            mag;
        longint            xy;
        longint            xn;
        fixed_t            m;
        logic [FP_INT-1:0] top;
        int                it;
        x   = 0;
        y   = 0;
        x2  = 0;
        y2  = 0;
        mag = 0;
        it  = 0;
        forever begin
            m   = fixed_t'(mag);
            top = m[FUNCW-1 -: FP_INT];  // escape test on integer bits
            if (!(int'(top) <= 4 && it < ITER_MAX)) begin
                break;
            end
            xy  = fmul(x, y);
            xn  = wrap(x2 - y2 + cre);
            y   = wrap((xy <<< 1) + cim);
            x   = xn;
            x2  = fmul(x, x);
            y2  = fmul(y, y);
            mag = wrap(x2 + y2);
            it++;
        end
        return it;
    endfunction

    // expected counts for a tile, scoreboard cleared
    task automatic load_tile(input cplx_t o, input fixed_t s);
        longint cre;
        longint cim;
        for (int ix = 0; ix < TILE_W; ix++) begin
            for (int iy = 0; iy < TILE_H; iy++) begin
                cre = wrap(longint'(o.re) + longint'(ix) * longint'(s));
                cim = wrap(longint'(o.im) + longint'(iy) * longint'(s));
                exp_iter[ix][iy] = model_iter(cre, cim);
                got_iter[ix][iy] = -1;
                seen[ix][iy]     = 0;
            end
        end
        out_count  = 0;
        done_count = 0;
        ooo_count  = 0;
        last_idx   = -1;
    endtask

    task automatic start_tile(input cplx_t o, input fixed_t s);
        @(posedge clk);
        start  <= 1'b1;
        origin <= o;
        step   <= s;
        @(posedge clk);
        start  <= 1'b0;
        @(negedge clk);
        check("busy after start", 1, int'(busy));
    endtask

    task automatic wait_tile_done;
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < TILE_TIMEOUT) begin
            @(negedge clk);
            n++;
            got = tile_done;
            if (!got) begin
                check("busy", 1, int'(busy));
            end else begin
                check("busy at tile_done", 0, int'(busy));  // falls with tile_done
            end
        end
        if (!got) begin
            errors++;
            $display("timeout: tile_done did not arrive within %0d cycles", TILE_TIMEOUT);
        end
        repeat (3 * NUM_ENG) @(negedge clk);  // room for any stray result
    endtask

    task automatic check_complete;
        check("out_valid count", TILE_PTS, out_count);
        check("tile_done pulses", 1, done_count);
        for (int ix = 0; ix < TILE_W; ix++) begin
            for (int iy = 0; iy < TILE_H; iy++) begin
                check($sformatf("seen[%0d][%0d]", ix, iy), 1, seen[ix][iy]);
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAIL, %0d errors", num, name, errors - err_before);
        end
    endtask

    // scoreboard, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            out_count++;
            if (int'(out_result.py) < TILE_H) begin
                seen[out_result.px][out_result.py]++;
                got_iter[out_result.px][out_result.py] = int'(out_result.iter);
                check("out_result.iter", exp_iter[out_result.px][out_result.py],
                      int'(out_result.iter));
                if (int'(out_result.py) * TILE_W + int'(out_result.px) < last_idx) begin
                    ooo_count++;
                end
                last_idx = int'(out_result.py) * TILE_W + int'(out_result.px);
            end else begin
                errors++;
                $display("result at %0t carries a row outside the tile", $time);
            end
        end
        if (!rst && tile_done) begin
            done_count++;
            check("results before tile_done", TILE_PTS, out_count);
        end
    end

    initial begin
        cplx_t  o;
        fixed_t s;
        int     e0;
        int     r;
        int     n;
        int     min_it;
        int     ooo_total;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        origin       = '0;
        step         = '0;
        seed         = 24957;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        e0   = errors;
        o.re = fixed_t'(-(1 << FBITS));      // -1.0
        o.im = fixed_t'(-(3 << (FBITS - 2))); // -0.75
        s    = fixed_t'(1 << (FBITS - 2));    // 0.25
        load_tile(o, s);
        start_tile(o, s);
        wait_tile_done();
        check("iter at c = 0", ITER_MAX, got_iter[4][3]);
        min_it = ITER_MAX;
        for (int ix = 0; ix < TILE_W; ix++) begin
            for (int iy = 0; iy < TILE_H; iy++) begin
                if (got_iter[ix][iy] >= 0 && got_iter[ix][iy] < min_it) begin
                    min_it = got_iter[ix][iy];
                end
            end
        end
        check("smallest iter below 16", 1, int'(min_it < 16));
        report_test(1, "fixed tile", e0);

        e0 = errors;
        check_complete();
        report_test(2, "completeness", e0);

        e0 = errors;
        o.re = fixed_t'(-(2 << FBITS));
        o.im = fixed_t'(-(1 << FBITS));
        s    = fixed_t'(1 << (FBITS - 3));
        load_tile(o, s);
        start_tile(o, s);
        repeat (6) @(posedge clk);
        start  <= 1'b1;                       // ignored, tile in progress
        origin <= '0;
        @(posedge clk);
        start  <= 1'b0;
        wait_tile_done();
        check_complete();
        report_test(3, "tile control", e0);

        e0        = errors;
        ooo_total = 0;
        for (int t = 0; t < 10; t++) begin
            r    = {$random(seed)} % (3 << FBITS);
            o.re = fixed_t'(r - (2 << FBITS));
            r    = {$random(seed)} % (3 << FBITS);
            o.im = fixed_t'(r - (2 << FBITS));
            r    = {$random(seed)} % (1 << (FBITS - 4));
            s    = fixed_t'(r + 1);            // up to 1/16
            load_tile(o, s);
            start_tile(o, s);
            wait_tile_done();
            check_complete();
            ooo_total += ooo_count;
        end
        $display("random tiles: %0d results arrived out of raster order", ooo_total);
        check("out of order results seen", 1, int'(ooo_total > 0));
        report_test(4, "random tiles", e0);

        e0   = errors;
        o.re = fixed_t'(-(3 << (FBITS - 1)));
        o.im = fixed_t'(-(1 << (FBITS - 1)));
        s    = fixed_t'(1 << (FBITS - 3));
        load_tile(o, s);
        start_tile(o, s);
        n = 0;
        while (out_count < 4 && n < TILE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (out_count < 4) begin
            errors++;
            $display("timeout: first results of the tile did not arrive");
        end
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("out_valid after reset", 0, int'(out_valid));
        check("busy after reset", 0, int'(busy));
        check("tile_done after reset", 0, int'(tile_done));
        load_tile(o, s);
        start_tile(o, s);
        wait_tile_done();
        check_complete();
        report_test(5, "reset mid tile", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- mandel_tile.f
hdl/fixed_pkg.sv
hdl/mandel_pkg.sv
hdl/fixed_mul.sv
hdl/mandel_engine.sv
hdl/point_dispatch.sv
hdl/result_collect.sv
hdl/mandel_tile.sv
tb/tb_mandel_tile.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_mandel_tile
RTL_TOP    ?= mandel_tile
FILELIST   ?= mandel_tile.f
LOG        ?= sim.log
PASS_MSG   ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
